// File: dv/tb_ncpu_rf.sv
// ********************
// testbench for the register-file execution slice.
// apb stimulus, reference register model, assertion checks.
// ********************
`timescale 1ns/100ps

module tb_ncpu_rf;

   import ncpu_rf_pkg::*;

   localparam int DW = 32;
   localparam int AW = 5;
   localparam int READY_TIMEOUT = 16;   // cycles allowed for pready.

   logic               clk;
   logic               rst_n;
   logic               psel;
   logic               penable;
   logic               pwrite;
   logic [PADDR_W-1:0] paddr;
   logic [DW-1:0]      pwdata;
   logic [DW-1:0]      prdata;
   logic               pready;
   logic               pslverr;

   logic [31:0]   lfsr;              // random state.
   logic [DW-1:0] model [32];        // reference register contents.
   logic [DW-1:0] model_imm;         // immediate last written.
   logic [DW-1:0] last_result;       // expected result register.
   int            issued;            // legal commands sent.
   int            data_errors;       // wrong prdata.
   int            resp_errors;       // wrong pslverr.
   int            timeouts;          // transfers that never finished.

   ncpu_rf_top #(.AW(AW), .DW(DW)) uut (
      .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;        // 40 ns period.
   end

   // ********************
   // random bits from a galois lfsr stepped once per bit.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [AW-1:0] rand_reg();
      logic [31:0] v;
      v = take_bits(AW);
      return v[AW-1:0];
   endfunction

   function automatic alu_op_e rand_op();
      logic [31:0] v;
      alu_op_e     op;
      v = take_bits(3);
      case (v % 5)
         0:       op = OP_ADD;
         1:       op = OP_SUB;
         2:       op = OP_AND;
         3:       op = OP_OR;
         default: op = OP_XOR;
      endcase
      return op;
   endfunction

   // ********************
   // reference model.
   function automatic logic [DW-1:0] predict(input alu_op_e op, input logic [DW-1:0] a,
                                             input logic [DW-1:0] b, input logic [DW-1:0] k);
      logic [DW-1:0] y;
      if (op == OP_LDI) y = k;              // immediate load.
      else if (op == OP_ADD) y = a + b;     // wraps at DW bits.
      else if (op == OP_SUB) y = a - b;
      else if (op == OP_AND) y = a & b;
      else if (op == OP_OR) y = a | b;
      else y = a ^ b;
      return y;
   endfunction

   function automatic logic [31:0] cmd_word(input logic [3:0] op, input logic [AW-1:0] rd,
                                            input logic [AW-1:0] rs1, input logic [AW-1:0] rs2);
      logic [31:0] w;
      w = '0;
      w[CMD_OP_LSB +: 4]   = op;
      w[CMD_RD_LSB +: AW]  = rd;
      w[CMD_RS1_LSB +: AW] = rs1;
      w[CMD_RS2_LSB +: AW] = rs2;
      return w;
   endfunction

   // ********************
   // apb transfers.
   task automatic wait_ready(output bit ok);
      int n;
      n = 0;
      ok = 1'b1;
      @(negedge clk);                       // access phase settled.
      while (pready !== 1'b1 && ok) begin
         n++;
         if (n > READY_TIMEOUT) begin
            $display("timeout: pready never rose in the apb access phase");
            timeouts++;
            ok = 1'b0;
         end else begin
            @(negedge clk);
         end
      end
   endtask

   task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [DW-1:0] data,
                            input logic exp_err);
      bit ok;
      @(posedge clk);
      psel    <= 1'b1;                      // setup phase.
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;                      // access phase.
      wait_ready(ok);
      if (ok) begin
         assert (pslverr === exp_err) else begin
            $display("FAIL pslverr (write %h): got %h, expected %h", addr, pslverr, exp_err);
            resp_errors++;
         end
      end
   endtask

   task automatic apb_read(input logic [PADDR_W-1:0] addr, input logic [DW-1:0] exp_data,
                           input logic exp_err);
      bit ok;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      wait_ready(ok);
      if (ok) begin
         assert (pslverr === exp_err) else begin
            $display("FAIL pslverr (read %h): got %h, expected %h", addr, pslverr, exp_err);
            resp_errors++;
         end
         if (!exp_err) begin
            assert (prdata === exp_data) else begin
               $display("FAIL prdata (read %h): got %h, expected %h", addr, prdata, exp_data);
               data_errors++;
            end
         end
      end
   endtask

   task automatic load_imm(input logic [DW-1:0] v);
      model_imm = v;
      apb_write(ADDR_IMM, v, 1'b0);
   endtask

   // legal command with the model updated before the write.
   task automatic run_cmd(input alu_op_e op, input logic [AW-1:0] rd,
                          input logic [AW-1:0] rs1, input logic [AW-1:0] rs2);
      last_result = predict(op, model[rs1], model[rs2], model_imm);
      if (rd != '0) model[rd] = last_result;   // r0 stays zero.
      issued++;
      apb_write(ADDR_CMD, cmd_word(op, rd, rs1, rs2), 1'b0);
   endtask

   // ********************
   // test sequence.
   initial begin
      logic [AW-1:0] d;
      logic [AW-1:0] s1;
      logic [AW-1:0] s2;
      alu_op_e       op;
      lfsr        = 32'h18a15929;
      rst_n       = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      data_errors = 0;
      resp_errors = 0;
      timeouts    = 0;
      issued      = 0;
      model_imm   = '0;
      last_result = '0;
      for (int i = 0; i < 32; i++) model[i] = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      apb_read(ADDR_IMM, '0, 1'b0);          // reset values.
      apb_read(ADDR_RESULT, '0, 1'b0);
      apb_read(ADDR_COUNT, '0, 1'b0);

      for (int i = 0; i < 24; i++) begin     // immediate loads.
         load_imm(take_bits(32));
         run_cmd(OP_LDI, rand_reg(), '0, '0);
         apb_read(ADDR_RESULT, last_result, 1'b0);
      end
      for (int i = 0; i < 32; i++) begin     // readback of every register through or with r0.
         d = i[AW-1:0];
         run_cmd(OP_OR, d, d, '0);
         apb_read(ADDR_RESULT, model[d], 1'b0);
      end

      for (int i = 0; i < 16; i++) begin     // dependent pairs through the bypass path.
         op = rand_op();
         d  = rand_reg();
         s1 = rand_reg();
         s2 = rand_reg();
         run_cmd(op, d, s1, s2);
         op = rand_op();
         s2 = take_bits(1) ? d : rand_reg();
         s1 = rand_reg();
         run_cmd(op, s1, d, s2);
         apb_read(ADDR_RESULT, last_result, 1'b0);
      end

      load_imm(32'h5a5a_0f0f);               // r0 ignores writes.
      run_cmd(OP_LDI, '0, '0, '0);
      apb_read(ADDR_RESULT, 32'h5a5a_0f0f, 1'b0);
      run_cmd(OP_OR, 5'd1, '0, '0);
      apb_read(ADDR_RESULT, '0, 1'b0);
      run_cmd(OP_LDI, 5'd2, '0, '0);         // nonzero result ahead of the error cases.

      apb_write(ADDR_CMD, cmd_word(4'hF, 5'd3, 5'd1, 5'd2), 1'b1);   // illegal opcodes.
      apb_write(ADDR_CMD, cmd_word(4'h6, 5'd4, 5'd4, 5'd4), 1'b1);
      apb_write(ADDR_RESULT, 32'hdead_beef, 1'b1);                    // read only.
      apb_write(ADDR_COUNT, 32'h0000_1234, 1'b1);
      apb_read(4'h2, '0, 1'b1);                                       // unmapped.
      apb_write(4'h6, 32'h1111_2222, 1'b1);
      apb_read(ADDR_CMD, '0, 1'b0);
      apb_read(ADDR_COUNT, {16'h0000, 16'(issued)}, 1'b0);
      apb_read(ADDR_RESULT, last_result, 1'b0);
      apb_read(ADDR_IMM, model_imm, 1'b0);

      for (int i = 0; i < 4; i++) begin      // final count.
         run_cmd(rand_op(), rand_reg(), rand_reg(), rand_reg());
      end
      apb_read(ADDR_RESULT, last_result, 1'b0);
      apb_read(ADDR_COUNT, {16'h0000, 16'(issued)}, 1'b0);

      @(posedge clk);
      psel    <= 1'b0;                       // bus idle.
      penable <= 1'b0;
      @(posedge clk);
      $display("errors: prdata %0d, pslverr %0d, timeouts %0d",
               data_errors, resp_errors, timeouts);
      if (data_errors + resp_errors + timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: hw/alu.sv
// ********************
// combinational alu.
// add, sub, logic ops and immediate load.
// ********************
`timescale 1ns/100ps

module alu #(
   parameter int DW = 32
) (
   input  ncpu_rf_pkg::alu_op_e op,
   input  logic [DW-1:0]        a,
   input  logic [DW-1:0]        b,
   input  logic [DW-1:0]        imm,
   output logic [DW-1:0]        y
);

   import ncpu_rf_pkg::*;

   // arithmetic wraps at DW bits.
   always_comb begin
      case (op)
         OP_ADD: begin
            y = a + b;            // sum.
         end
         OP_SUB: begin
            y = a - b;            // difference.
         end
         OP_AND: begin
            y = a & b;
         end
         OP_OR: begin
            y = a | b;
         end
         OP_XOR: begin
            y = a ^ b;
         end
         OP_LDI: begin
            y = imm;              // immediate load.
         end
         default: begin
            y = '0;               // illegal codes never get issued.
         end
      endcase
   end

endmodule

// File: hw/apb_cmd_regs.sv
// ********************
// apb slave for the execution slice.
// holds the immediate, issues commands, reports result and count.
// ********************
`timescale 1ns/100ps

module apb_cmd_regs #(
   parameter int AW = 5,
   parameter int DW = 32
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [ncpu_rf_pkg::PADDR_W-1:0] paddr,
   input  logic [DW-1:0]                   pwdata,
   output logic [DW-1:0]                   prdata,
   output logic                            pready,
   output logic                            pslverr,
   output logic                            issue,
   output ncpu_rf_pkg::alu_op_e            op,
   output logic [AW-1:0]                   rd,
   output logic [AW-1:0]                   rs1,
   output logic [AW-1:0]                   rs2,
   output logic [DW-1:0]                   imm,
   input  logic                            wb_valid,
   input  logic [DW-1:0]                   result
);

   import ncpu_rf_pkg::*;

   logic          access;       // apb access phase.
   logic          op_legal;     // opcode field names a real op.
   logic          err;          // access is rejected.
   logic [DW-1:0] imm_q;        // immediate register.
   logic [15:0]   count_q;      // retired commands.

   assign access = psel && penable;
   assign pready = 1'b1;        // no wait states.

   // command fields straight off the write data.
   assign op  = alu_op_e'(pwdata[CMD_OP_LSB +: $bits(alu_op_e)]);
   assign rd  = pwdata[CMD_RD_LSB  +: AW];
   assign rs1 = pwdata[CMD_RS1_LSB +: AW];
   assign rs2 = pwdata[CMD_RS2_LSB +: AW];
   assign imm = imm_q;

   // only legality check on the opcode.
   always_comb begin
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI: op_legal = 1'b1;
         default:                                       op_legal = 1'b0;
      endcase
   end

   // ********************
   // decode.
   always_comb begin
      case (paddr)
         ADDR_IMM:    err = 1'b0;
         ADDR_CMD:    err = pwrite && !op_legal;   // bad opcode.
         ADDR_RESULT: err = pwrite;                // read only.
         ADDR_COUNT:  err = pwrite;                // read only.
         default:     err = 1'b1;                  // unmapped.
      endcase
   end

   assign pslverr = access && err;
   assign issue   = access && pwrite && (paddr == ADDR_CMD) && op_legal;

   always_comb begin
      prdata = '0;                                  // cmd reads zero.
      if (access && !pwrite) begin
         case (paddr)
            ADDR_IMM:    prdata = imm_q;
            ADDR_RESULT: prdata = result;
            ADDR_COUNT:  prdata = DW'(count_q);     // zero extended.
            default:     prdata = '0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         imm_q   <= '0;
         count_q <= '0;
      end else begin
         if (access && pwrite && (paddr == ADDR_IMM)) imm_q <= pwdata;
         if (wb_valid) count_q <= count_q + 16'd1;  // wraps at 2^16.
      end
   end

endmodule

// File: hw/exec_pipe.sv
// ********************
// execution pipe: issue, operand and writeback stages.
// wraps the register file and the alu.
// ********************
`timescale 1ns/100ps

module exec_pipe #(
   parameter int AW = 5,
   parameter int DW = 32
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 issue,
   input  ncpu_rf_pkg::alu_op_e op,
   input  logic [AW-1:0]        rd,
   input  logic [AW-1:0]        rs1,
   input  logic [AW-1:0]        rs2,
   input  logic [DW-1:0]        imm,
   output logic                 wb_valid,
   output logic [DW-1:0]        result
);

   import ncpu_rf_pkg::*;

   // ********************
   // operand stage state.
   logic          opnd_valid;      // operands arrive this cycle.
   alu_op_e       opnd_op;         // opcode riding with the read.
   logic [AW-1:0] opnd_rd;         // destination riding with the read.
   logic [DW-1:0] opnd_imm;        // immediate riding with the read.
   logic [DW-1:0] rdata1;          // source 1 from the register file.
   logic [DW-1:0] rdata2;          // source 2 from the register file.
   logic [DW-1:0] alu_y;           // alu output.

   // ********************
   // writeback stage state.
   logic [AW-1:0] wb_rd;           // destination of the writeback.
   logic [DW-1:0] result_q;        // last value written back.
   logic          wb_valid_q;      // writeback this cycle.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         opnd_valid <= 1'b0;
         wb_valid_q <= 1'b0;
         result_q   <= '0;
      end else begin
         opnd_valid <= issue;
         wb_valid_q <= opnd_valid;
         if (opnd_valid) result_q <= alu_y;   // held until the next command.
      end
   end

   // payload follows the valid bits.
   always_ff @(posedge clk) begin
      if (issue) begin
         opnd_op  <= op;
         opnd_rd  <= rd;
         opnd_imm <= imm;
      end
      if (opnd_valid) wb_rd <= opnd_rd;
   end

   regfile_2r1w #(.AW(AW), .DW(DW)) u_rf (
      .clk    (clk),
      .rst_n  (rst_n),
      .re     (issue),          // read at issue.
      .rs1    (rs1),
      .rs2    (rs2),
      .rd     (wb_rd),
      .we     (wb_valid_q),     // write two cycles later.
      .wdata  (result_q),
      .rdata1 (rdata1),
      .rdata2 (rdata2));

   alu #(.DW(DW)) u_alu (
      .op  (opnd_op),
      .a   (rdata1),
      .b   (rdata2),
      .imm (opnd_imm),
      .y   (alu_y));

   assign wb_valid = wb_valid_q;   // r0 writes still retire.
   assign result   = result_q;

endmodule

// File: hw/ncpu_rf_pkg.sv
// ********************
// ncpu register-file slice shared definitions.
// opcodes, apb register map and command word layout.
// ********************
package ncpu_rf_pkg;

   // ********************
   // alu opcodes, every other code is illegal.
   typedef enum logic [3:0] {
      OP_ADD = 4'h0,   // rd = rs1 + rs2.
      OP_SUB = 4'h1,   // rd = rs1 - rs2.
      OP_AND = 4'h2,   // rd = rs1 & rs2.
      OP_OR  = 4'h3,   // rd = rs1 | rs2.
      OP_XOR = 4'h4,   // rd = rs1 ^ rs2.
      OP_LDI = 4'h5    // rd = immediate.
   } alu_op_e;

   // ********************
   // apb register map.
   localparam int PADDR_W = 4;                          // byte address width.

   localparam logic [PADDR_W-1:0] ADDR_IMM    = 4'h0;  // immediate, r/w.
   localparam logic [PADDR_W-1:0] ADDR_CMD    = 4'h4;  // command, write issues.
   localparam logic [PADDR_W-1:0] ADDR_RESULT = 4'h8;  // last result, ro.
   localparam logic [PADDR_W-1:0] ADDR_COUNT  = 4'hC;  // retired count, ro.

   // ********************
   // command word layout, one field per byte.
   // register fields use the low AW bits of their byte.
   localparam int CMD_OP_LSB  = 0;    // opcode.
   localparam int CMD_RD_LSB  = 8;    // destination.
   localparam int CMD_RS1_LSB = 16;   // first source.
   localparam int CMD_RS2_LSB = 24;   // second source.

endpackage

// File: hw/ncpu_rf_top.sv
// ********************
// top level of the register-file execution slice.
// apb command block in front of the execution pipe.
// ********************
`timescale 1ns/100ps

module ncpu_rf_top #(
   parameter int AW = 5,
   parameter int DW = 32
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [ncpu_rf_pkg::PADDR_W-1:0] paddr,
   input  logic [DW-1:0]                   pwdata,
   output logic [DW-1:0]                   prdata,
   output logic                            pready,
   output logic                            pslverr
);

   import ncpu_rf_pkg::*;

   logic          issue;      // command pulse.
   alu_op_e       op;         // command opcode.
   logic [AW-1:0] rd;         // destination index.
   logic [AW-1:0] rs1;        // first source index.
   logic [AW-1:0] rs2;        // second source index.
   logic [DW-1:0] imm;        // immediate operand.
   logic          wb_valid;   // retirement pulse.
   logic [DW-1:0] result;     // last result.

   apb_cmd_regs #(.AW(AW), .DW(DW)) u_regs (
      .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .issue(issue), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2),
      .imm(imm), .wb_valid(wb_valid), .result(result));

   exec_pipe #(.AW(AW), .DW(DW)) u_pipe (
      .clk(clk), .rst_n(rst_n), .issue(issue), .op(op), .rd(rd), .rs1(rs1),
      .rs2(rs2), .imm(imm), .wb_valid(wb_valid), .result(result));

endmodule

// File: hw/regfile_2r1w.sv
// ********************
// two-read, one-write register file.
// two ram copies share the write port, r0 reads as zero.
// ********************
`timescale 1ns/100ps

module regfile_2r1w #(
   parameter int AW = 5,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          re,
   input  logic [AW-1:0] rs1,
   input  logic [AW-1:0] rs2,
   input  logic [AW-1:0] rd,
   input  logic          we,
   input  logic [DW-1:0] wdata,
   output logic [DW-1:0] rdata1,
   output logic [DW-1:0] rdata2
);

   logic          we_ram;                // write enable, r0 masked.
   logic          rs1_zero;              // last rs1 read was r0.
   logic          rs2_zero;              // last rs2 read was r0.
   logic [DW-1:0] dout1;                 // raw word, port 1.
   logic [DW-1:0] dout2;                 // raw word, port 2.

   assign we_ram = we && (rd != '0);     // r0 is never written.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rs1_zero <= 1'b0;
         rs2_zero <= 1'b0;
      end else if (re) begin
         rs1_zero <= (rs1 == '0);        // tracks the read in flight.
         rs2_zero <= (rs2 == '0);
      end
   end

   // one copy per read port, same write data.
   sdpram_sclk #(.AW(AW), .DW(DW)) u_ram1 (
      .clk(clk), .rst_n(rst_n), .raddr(rs1), .re(re),
      .waddr(rd), .we(we_ram), .din(wdata), .dout(dout1));
   sdpram_sclk #(.AW(AW), .DW(DW)) u_ram2 (
      .clk(clk), .rst_n(rst_n), .raddr(rs2), .re(re),
      .waddr(rd), .we(we_ram), .din(wdata), .dout(dout2));

   assign rdata1 = rs1_zero ? '0 : dout1;   // r0 forced to zero.
   assign rdata2 = rs2_zero ? '0 : dout2;

endmodule

// File: hw/sdpram_sclk.sv
// ********************
// simple dual-port ram, single clock.
// registered read, same-address write goes through a bypass.
// ********************
`timescale 1ns/100ps

module sdpram_sclk #(
   parameter int AW = 5,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic [AW-1:0] raddr,
   input  logic          re,
   input  logic [AW-1:0] waddr,
   input  logic          we,
   input  logic [DW-1:0] din,
   output logic [DW-1:0] dout
);

   localparam int DEPTH = 1 << AW;   // words in the array.

   logic [DW-1:0] mem [DEPTH];       // storage array.
   logic [DW-1:0] dout_r;            // registered array word.
   logic [DW-1:0] din_r;             // write data seen on the last read.
   logic          bypass;            // last read collided with a write.

   // array starts all zero, r0 relies on it.
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // ********************
   // bypass tracking.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bypass <= 1'b0;
      end else if (re) begin
         bypass <= we && (waddr == raddr);   // held until the next read.
      end
   end

   always_ff @(posedge clk) begin
      if (re) din_r <= din;                   // captured on every read.
   end

   // ********************
   // array write and read.
   always @(posedge clk) begin
      if (we) mem[waddr] <= din;
      if (re) dout_r <= mem[raddr];           // old word on a collision.
   end

   assign dout = bypass ? din_r : dout_r;     // fresh data wins.

endmodule

// File: ncpu_rf.f
hw/ncpu_rf_pkg.sv
hw/sdpram_sclk.sv
hw/regfile_2r1w.sv
hw/alu.sv
hw/exec_pipe.sv
hw/apb_cmd_regs.sv
hw/ncpu_rf_top.sv
dv/tb_ncpu_rf.sv
